// File: src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Integer register and data path width
`define RV_XLEN 32

// Word address bits of the data memory
// 8 bits give 256 words
`define RV_DMEM_AW 8

// One bank per byte lane of a word
`define RV_NBANKS 4

`endif

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  // Load/store width, taken straight from funct3
  // Stores reuse LB/LH/LW for SB/SH/SW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } width_e;

  // Source of the value written back to rd
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,
    RES_TGT = 3'd3,
    RES_CSR = 3'd4,
    RES_M   = 3'd5
  } res_src_e;

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP = 32'h0000_0013;

endpackage

// File: src/rv_pipe_pkg.sv
`include "rv_defs.svh"

package rv_pipe_pkg;

  // Instruction state entering MEM
  typedef struct packed {
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    rv_isa_pkg::res_src_e     res_src;
    logic [31:0]              instr;
    logic [4:0]               rd;
    rv_isa_pkg::width_e       funct3;
    // Effective address for loads and stores
    logic [`RV_XLEN-1:0]      alu_result;
    // Store data, already forwarded in EX
    logic [`RV_XLEN-1:0]      rs2_data;
    logic [`RV_XLEN-1:0]      pc_plus4;
    logic [`RV_XLEN-1:0]      jb_target;
    logic [`RV_XLEN-1:0]      csr_rdata;
    logic [`RV_XLEN-1:0]      m_result;
  } ex_mem_t;

  // Instruction state seen by WB
  typedef struct packed {
    logic                     reg_write;
    rv_isa_pkg::res_src_e     res_src;
    logic [31:0]              instr;
    logic [4:0]               rd;
    logic [`RV_XLEN-1:0]      alu_result;
    // Extended load result, formatted in the WB cycle
    logic [`RV_XLEN-1:0]      load_data;
    logic [`RV_XLEN-1:0]      pc_plus4;
    logic [`RV_XLEN-1:0]      jb_target;
    logic [`RV_XLEN-1:0]      csr_rdata;
    logic [`RV_XLEN-1:0]      m_result;
  } mem_wb_t;

  // Request broadcast to all byte banks
  typedef struct packed {
    logic                     ren;
    logic                     we;
    logic [`RV_DMEM_AW-1:0]   addr;
    logic [31:0]              wdata;
    logic [3:0]               wstrb;
  } dmem_req_t;

endpackage

// File: src/rv_st_fmt.sv
module rv_st_fmt (
  input  logic [31:0]        data,
  input  logic [1:0]         offset,
  input  rv_isa_pkg::width_e width,
  output logic [31:0]        wdata,
  output logic [3:0]         wstrb
);

  // Lanes carry copies of the low byte or halfword
  // so any strobed lane sees the right value
  always_comb begin
    case (width)
      rv_isa_pkg::LB: begin
        wdata = {4{data[7:0]}};
        // One lane, picked by the full offset
        wstrb = 4'b0001 << offset;
      end
      rv_isa_pkg::LH: begin
        wdata = {2{data[15:0]}};
        // Upper or lower half, offset[0] ignored
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // SW and any unlisted code write the full word
        wdata = data;
        wstrb = 4'b1111;
      end
    endcase
  end

endmodule

// File: src/rv_ld_fmt.sv
module rv_ld_fmt (
  input  logic [31:0]        rdata,
  input  logic [1:0]         offset,
  input  rv_isa_pkg::width_e width,
  output logic [31:0]        data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Addressed byte moved down to bit 0
  assign byte_sel = rdata[{offset, 3'b000} +: 8];

  // Halfword picked by offset[1] only
  assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (width)
      // Signed loads replicate the top bit
      rv_isa_pkg::LB:  data = {{24{byte_sel[7]}}, byte_sel};
      rv_isa_pkg::LH:  data = {{16{half_sel[15]}}, half_sel};
      // Unsigned loads fill with zeros
      rv_isa_pkg::LBU: data = {24'b0, byte_sel};
      rv_isa_pkg::LHU: data = {16'b0, half_sel};
      // LW, word as read
      default:         data = rdata;
    endcase
  end

endmodule

// File: src/rv_dmem_bank.sv
`include "rv_defs.svh"

module rv_dmem_bank (
  input  logic                   clk,
  input  logic                   we,
  input  logic                   re,
  input  logic [`RV_DMEM_AW-1:0] addr,
  input  logic [7:0]             wdata,
  output logic [7:0]             rdata
);

  // One byte lane of the data memory
  logic [7:0] mem [2**`RV_DMEM_AW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // Read samples the array before this edge's write lands
    // so a same-address access returns the old byte
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: src/rv_stage_mem.sv
`include "rv_defs.svh"

module rv_stage_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  rv_pipe_pkg::ex_mem_t   ex_mem,
  output rv_pipe_pkg::dmem_req_t dmem_req,
  input  logic [31:0]            dmem_rdata,
  output rv_pipe_pkg::mem_wb_t   mem_wb,
  output logic [`RV_XLEN-1:0]    result_mem
);

  logic [31:0]          st_wdata;
  logic [3:0]           st_wstrb;
  logic [31:0]          ld_data;
  rv_pipe_pkg::mem_wb_t wb_q;
  // Load shape kept for the WB cycle, not part of the bundle
  rv_isa_pkg::width_e   funct3_wb;
  logic [1:0]           offset_wb;

  // Store data lanes and byte enables from width and address
  rv_st_fmt u_st_fmt (
    .data   (ex_mem.rs2_data),
    .offset (ex_mem.alu_result[1:0]),
    .width  (ex_mem.funct3),
    .wdata  (st_wdata),
    .wstrb  (st_wstrb)
  );

  // Memory request
  always_comb begin
    // A stalled slot repeats next cycle, so nothing is issued now
    dmem_req.ren   = ex_mem.mem_read & ~stall;
    dmem_req.we    = ex_mem.mem_write & ~stall;
    // Word address, byte offset goes to the formatters
    dmem_req.addr  = ex_mem.alu_result[`RV_DMEM_AW+1:2];
    dmem_req.wdata = st_wdata;
    // No lane written unless the store is really issued
    dmem_req.wstrb = st_wstrb & {4{dmem_req.we}};
  end

  // Forwarding value of the instruction in MEM
  // Load results are not ready yet with registered memory
  always_comb begin
    case (ex_mem.res_src)
      rv_isa_pkg::RES_M:   result_mem = ex_mem.m_result;
      rv_isa_pkg::RES_TGT: result_mem = ex_mem.jb_target;
      default:             result_mem = ex_mem.alu_result;
    endcase
  end

  // MEM/WB register, held while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_q       <= '0;
      wb_q.instr <= rv_isa_pkg::I_NOP;
      funct3_wb  <= rv_isa_pkg::LB;
      offset_wb  <= 2'b00;
    end else if (!stall) begin
      wb_q.reg_write  <= ex_mem.reg_write;
      wb_q.res_src    <= ex_mem.res_src;
      wb_q.instr      <= ex_mem.instr;
      wb_q.rd         <= ex_mem.rd;
      wb_q.alu_result <= ex_mem.alu_result;
      wb_q.pc_plus4   <= ex_mem.pc_plus4;
      wb_q.jb_target  <= ex_mem.jb_target;
      wb_q.csr_rdata  <= ex_mem.csr_rdata;
      wb_q.m_result   <= ex_mem.m_result;
      funct3_wb       <= ex_mem.funct3;
      offset_wb       <= ex_mem.alu_result[1:0];
    end
  end

  // Bank output is WB-timed, format it with the registered shape
  rv_ld_fmt u_ld_fmt (
    .rdata  (dmem_rdata),
    .offset (offset_wb),
    .width  (funct3_wb),
    .data   (ld_data)
  );

  // wb_q.load_data stays at its reset value
  // the live load result replaces it here
  always_comb begin
    mem_wb           = wb_q;
    mem_wb.load_data = ld_data;
  end

endmodule

// File: src/rv_mem_top.sv
`include "rv_defs.svh"

module rv_mem_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  rv_pipe_pkg::ex_mem_t ex_mem,
  output rv_pipe_pkg::mem_wb_t mem_wb,
  output logic [`RV_XLEN-1:0]  result_mem
);

  rv_pipe_pkg::dmem_req_t dmem_req;
  logic [31:0]            dmem_rdata;

  rv_stage_mem u_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .ex_mem     (ex_mem),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .mem_wb     (mem_wb),
    .result_mem (result_mem)
  );

  // Byte lane i of every word lives in bank i
  // strobes already carry the write enable
  for (genvar i = 0; i < `RV_NBANKS; i++) begin : g_bank
    rv_dmem_bank u_bank (
      .clk   (clk),
      .we    (dmem_req.wstrb[i]),
      .re    (dmem_req.ren),
      .addr  (dmem_req.addr),
      .wdata (dmem_req.wdata[8*i +: 8]),
      .rdata (dmem_rdata[8*i +: 8])
    );
  end

endmodule

// File: tests/rv_mem_tb.sv
module rv_mem_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_RANDOM   = 200;
  // Upper bound on reset, directed and flush cycles
  localparam int N_DIRECTED = 80;
  localparam int N_OPS      = N_RANDOM + N_DIRECTED;
  // Test region starts at word 64
  // Byte index within the region kept in the low 6 bits
  localparam logic [31:0] BASE = 32'h0000_0100;

  logic                 clk;
  logic                 rst_n;
  logic                 stall;
  rv_pipe_pkg::ex_mem_t ex_mem;
  rv_pipe_pkg::mem_wb_t mem_wb;
  logic [31:0]          result_mem;

  integer seed = 18327;

  // Reference memory for the 64-byte test region
  logic [7:0]           ref_mem [64];
  // Predicted MEM/WB contents
  rv_pipe_pkg::mem_wb_t exp_wb;
  logic [31:0]          exp_load;
  logic                 load_valid;
  logic                 captured;

  rv_isa_pkg::width_e ld_widths [5] = '{rv_isa_pkg::LB, rv_isa_pkg::LH, rv_isa_pkg::LW,
                                        rv_isa_pkg::LBU, rv_isa_pkg::LHU};
  rv_isa_pkg::width_e st_widths [3] = '{rv_isa_pkg::LB, rv_isa_pkg::LH, rv_isa_pkg::LW};

  rv_mem_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .ex_mem     (ex_mem),
    .mem_wb     (mem_wb),
    .result_mem (result_mem)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog sized from the operation count
  initial begin
    #(N_OPS * CLK_PERIOD * 4);
    $display("Timeout: the stimulus did not finish within the expected time");
    $display("=== FAIL ===");
    $fatal(1);
  end

  task automatic report_error(input string msg);
    $display("** Error @ %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic rv_pipe_pkg::ex_mem_t idle_bundle();
    rv_pipe_pkg::ex_mem_t e;
    e       = '0;
    e.instr = rv_isa_pkg::I_NOP;
    return e;
  endfunction

  // Forwarding source chosen by res_src
  function automatic logic [31:0] expected_fwd(input rv_pipe_pkg::ex_mem_t e);
    case (e.res_src)
      rv_isa_pkg::RES_M:   return e.m_result;
      rv_isa_pkg::RES_TGT: return e.jb_target;
      default:             return e.alu_result;
    endcase
  endfunction

  // Bundle with the late-formatted field masked off
  function automatic rv_pipe_pkg::mem_wb_t without_load(input rv_pipe_pkg::mem_wb_t w);
    rv_pipe_pkg::mem_wb_t t;
    t           = w;
    t.load_data = '0;
    return t;
  endfunction

  // Byte index rounded down to the access size
  function automatic logic [5:0] aligned(input logic [5:0] idx, input rv_isa_pkg::width_e w);
    case (w)
      rv_isa_pkg::LH, rv_isa_pkg::LHU: return {idx[5:1], 1'b0};
      rv_isa_pkg::LW:                  return {idx[5:2], 2'b00};
      default:                         return idx;
    endcase
  endfunction

  // Little-endian load from the reference bytes
  function automatic logic [31:0] model_load(input logic [31:0] addr,
                                             input rv_isa_pkg::width_e w);
    logic [5:0] idx;
    logic [5:0] h;
    logic [5:0] wd;
    idx = addr[5:0];
    h   = {idx[5:1], 1'b0};
    wd  = {idx[5:2], 2'b00};
    case (w)
      rv_isa_pkg::LB:  return {{24{ref_mem[idx][7]}}, ref_mem[idx]};
      rv_isa_pkg::LBU: return {24'b0, ref_mem[idx]};
      rv_isa_pkg::LH:  return {{16{ref_mem[h+6'd1][7]}}, ref_mem[h+6'd1], ref_mem[h]};
      rv_isa_pkg::LHU: return {16'b0, ref_mem[h+6'd1], ref_mem[h]};
      default: return {ref_mem[wd+6'd3], ref_mem[wd+6'd2], ref_mem[wd+6'd1], ref_mem[wd]};
    endcase
  endfunction

  task automatic model_store(input logic [31:0] addr, input rv_isa_pkg::width_e w,
                             input logic [31:0] d);
    logic [5:0] idx;
    logic [5:0] h;
    logic [5:0] wd;
    idx = addr[5:0];
    h   = {idx[5:1], 1'b0};
    wd  = {idx[5:2], 2'b00};
    case (w)
      rv_isa_pkg::LB: ref_mem[idx] = d[7:0];
      rv_isa_pkg::LH: begin
        ref_mem[h]       = d[7:0];
        ref_mem[h+6'd1]  = d[15:8];
      end
      default: begin
        ref_mem[wd]      = d[7:0];
        ref_mem[wd+6'd1] = d[15:8];
        ref_mem[wd+6'd2] = d[23:16];
        ref_mem[wd+6'd3] = d[31:24];
      end
    endcase
  endtask

  // Random non-memory bundle
  task automatic random_bundle(output rv_pipe_pkg::ex_mem_t b);
    logic [31:0] r;
    r            = $random(seed);
    b.reg_write  = r[0];
    b.rd         = r[12:8];
    b.mem_read   = 1'b0;
    b.mem_write  = 1'b0;
    b.funct3     = rv_isa_pkg::LW;
    r            = {$random(seed)} % 6;
    b.res_src    = rv_isa_pkg::res_src_e'(r[2:0]);
    b.instr      = $random(seed);
    b.alu_result = $random(seed);
    b.rs2_data   = $random(seed);
    b.pc_plus4   = $random(seed);
    b.jb_target  = $random(seed);
    b.csr_rdata  = $random(seed);
    b.m_result   = $random(seed);
  endtask

  task automatic make_mem_op(input logic rd_en, input logic wr_en,
                             input rv_isa_pkg::width_e w, input logic [5:0] idx,
                             input logic [31:0] data, output rv_pipe_pkg::ex_mem_t b);
    random_bundle(b);
    b.mem_read   = rd_en;
    b.mem_write  = wr_en;
    b.reg_write  = rd_en;
    b.funct3     = w;
    b.alu_result = BASE | {26'b0, idx};
    b.rs2_data   = data;
    if (rd_en) begin
      b.res_src = rv_isa_pkg::RES_MEM;
    end
  endtask

  // One cycle of stimulus
  task automatic issue(input rv_pipe_pkg::ex_mem_t b, input logic s);
    @(posedge clk);
    ex_mem <= b;
    stall  <= s;
  endtask

  // Expected MEM/WB and reference memory advance on unstalled edges
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_wb       <= '0;
      exp_wb.instr <= rv_isa_pkg::I_NOP;
      load_valid   <= 1'b0;
      captured     <= 1'b0;
    end else if (!stall) begin
      captured            <= 1'b1;
      exp_wb.reg_write    <= ex_mem.reg_write;
      exp_wb.res_src      <= ex_mem.res_src;
      exp_wb.instr        <= ex_mem.instr;
      exp_wb.rd           <= ex_mem.rd;
      exp_wb.alu_result   <= ex_mem.alu_result;
      exp_wb.pc_plus4     <= ex_mem.pc_plus4;
      exp_wb.jb_target    <= ex_mem.jb_target;
      exp_wb.csr_rdata    <= ex_mem.csr_rdata;
      exp_wb.m_result     <= ex_mem.m_result;
      load_valid          <= ex_mem.mem_read;
      // Load sees the bytes before this edge's store
      if (ex_mem.mem_read) begin
        exp_load <= model_load(ex_mem.alu_result, ex_mem.funct3);
      end
      if (ex_mem.mem_write) begin
        model_store(ex_mem.alu_result, ex_mem.funct3, ex_mem.rs2_data);
      end
    end
  end

  a_reset_nop: assert property (@(posedge clk) disable iff (!rst_n)
    !captured |-> (mem_wb.reg_write == 1'b0 && mem_wb.instr == rv_isa_pkg::I_NOP))
    else report_error("mem_wb is not a NOP before the first capture");

  a_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    result_mem == expected_fwd(ex_mem))
    else report_error("result_mem does not match the selected source");

  a_fields: assert property (@(posedge clk) disable iff (!rst_n)
    without_load(mem_wb) == without_load(exp_wb))
    else report_error("mem_wb fields differ from the bundle issued a cycle earlier");

  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> mem_wb.load_data == exp_load)
    else report_error("mem_wb.load_data differs from the reference memory");

  // Whole bundle including load_data, unread lanes may still be unknown
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(rst_n) && $past(stall)) |-> mem_wb === $past(mem_wb))
    else report_error("mem_wb changed while stalled");

  initial begin
    rv_pipe_pkg::ex_mem_t b;
    logic [31:0]          r;
    logic [5:0]           idx;
    int                   kind;
    logic                 s;
    ex_mem = idle_bundle();
    stall  = 1'b0;
    rst_n  = 1'b0;
    repeat (2) @(posedge clk);
    // Leave reset while stalled so no capture precedes the NOP check
    random_bundle(b);
    b.reg_write = 1'b1;
    rst_n  <= 1'b1;
    stall  <= 1'b1;
    ex_mem <= b;
    issue(b, 1'b1);
    // Fill the region with full words
    for (int w = 0; w < 16; w++) begin
      make_mem_op(1'b0, 1'b1, rv_isa_pkg::LW, 6'(w * 4), $random(seed), b);
      issue(b, 1'b0);
    end
    // Store seen only while stalled, then read back
    make_mem_op(1'b0, 1'b1, rv_isa_pkg::LB, 6'd9, 32'h0000_00a5, b);
    repeat (3) issue(b, 1'b1);
    make_mem_op(1'b1, 1'b0, rv_isa_pkg::LW, 6'd8, 32'h0, b);
    issue(b, 1'b0);
    // Every store width at every legal offset, then all load widths
    for (int sw = 0; sw < 3; sw++) begin
      for (int off = 0; off < 4; off++) begin
        if (aligned(6'(off), st_widths[sw]) == 6'(off)) begin
          make_mem_op(1'b0, 1'b1, st_widths[sw], 6'(16 + off), $random(seed), b);
          issue(b, 1'b0);
          for (int lw = 0; lw < 5; lw++) begin
            idx = aligned(6'(16 + off), ld_widths[lw]);
            make_mem_op(1'b1, 1'b0, ld_widths[lw], idx, 32'h0, b);
            issue(b, 1'b0);
          end
        end
      end
    end
    // Store and load on one address in one cycle return the old data
    make_mem_op(1'b1, 1'b1, rv_isa_pkg::LW, 6'd20, $random(seed), b);
    issue(b, 1'b0);
    make_mem_op(1'b1, 1'b1, rv_isa_pkg::LH, 6'd22, $random(seed), b);
    issue(b, 1'b0);
    make_mem_op(1'b1, 1'b0, rv_isa_pkg::LW, 6'd20, 32'h0, b);
    issue(b, 1'b0);
    // Random mix of loads, stores, both, and plain ops with random stalls
    for (int i = 0; i < N_RANDOM; i++) begin
      kind = {$random(seed)} % 4;
      r    = $random(seed);
      if (kind == 0) begin
        idx = aligned(r[5:0], ld_widths[r[10:8] % 5]);
        make_mem_op(1'b1, 1'b0, ld_widths[r[10:8] % 5], idx, 32'h0, b);
      end else if (kind == 1) begin
        idx = aligned(r[5:0], st_widths[r[9:8] % 3]);
        make_mem_op(1'b0, 1'b1, st_widths[r[9:8] % 3], idx, $random(seed), b);
      end else if (kind == 2) begin
        idx = aligned(r[5:0], st_widths[r[9:8] % 3]);
        make_mem_op(1'b1, 1'b1, st_widths[r[9:8] % 3], idx, $random(seed), b);
      end else begin
        random_bundle(b);
      end
      s = ({$random(seed)} % 4) == 0;
      issue(b, s);
    end
    // Drain so the last operations reach the checks
    repeat (3) issue(idle_bundle(), 1'b0);
    @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: files.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_st_fmt.sv
src/rv_ld_fmt.sv
src/rv_dmem_bank.sv
src/rv_stage_mem.sv
src/rv_mem_top.sv
tests/rv_mem_tb.sv
